// File: dnc_addressing.f
+incdir+.
dnc_types_pkg.sv
dnc_ctrl_pkg.sv
dnc_row_if.sv
dnc_operand_loader.sv
dnc_memory_matrix.sv
dnc_read_head.sv
dnc_read_collector.sv
dnc_addressing_top.sv
dnc_addressing_tb.sv

// File: dnc_addressing_tb.sv
//////////////////////////////////////////////////////////////////////
// Self-checking testbench for the memory update and read datapath.
// Streams operands, starts operations and compares the read stream
// against a Q8.8 reference model of the memory matrix.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_addressing_tb;

  timeunit 1ns;
  timeprecision 1ps;

  localparam int N = `DNC_ROWS;
  localparam int W = `DNC_WORD;
  localparam int R = `DNC_HEADS;
  localparam int NUM_OPS = 9;
  localparam int OP_CYCLES = 2 * N + R * W + 40;

  typedef logic [2*`DNC_DATA_W-1:0] wide_t;

  logic                     CLK;
  logic                     RST;
  logic                     load_valid;
  dnc_ctrl_pkg::operand_e   load_kind;
  dnc_types_pkg::head_idx_t load_head;
  dnc_types_pkg::elem_idx_t load_index;
  dnc_types_pkg::data_t     load_data;
  logic                     start;
  logic                     ready;
  dnc_types_pkg::data_t     r_out;
  logic                     r_out_i_enable;
  logic                     r_out_k_enable;

  integer seed = 32'hc356;

  // Operands of the next operation and the model memory
  dnc_types_pkg::data_t op_ww [N];
  dnc_types_pkg::data_t op_erase [W];
  dnc_types_pkg::data_t op_add [W];
  dnc_types_pkg::data_t op_rw [R][N];
  dnc_types_pkg::data_t model_mem [N][W];
  dnc_types_pkg::data_t exp_q [$];

  int elem_cnt = 0;
  int head_cnt = 0;
  int ready_cnt = 0;

  dnc_addressing_top u_dnc_addressing_top (
    .CLK            (CLK),
    .RST            (RST),
    .load_valid     (load_valid),
    .load_kind      (load_kind),
    .load_head      (load_head),
    .load_index     (load_index),
    .load_data      (load_data),
    .start          (start),
    .ready          (ready),
    .r_out          (r_out),
    .r_out_i_enable (r_out_i_enable),
    .r_out_k_enable (r_out_k_enable)
  );

  initial begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  //////////////////////////////////////////////////////////////////////
  // Reference model
  //////////////////////////////////////////////////////////////////////

  // Q8.8 product on 32 bits shifted down by the fraction and cut to 16 bits
  function automatic dnc_types_pkg::data_t q_mul(dnc_types_pkg::data_t a,
                                                 dnc_types_pkg::data_t b);
    wide_t p;
    p = wide_t'(a) * wide_t'(b);
    return p[`DNC_FRAC +: `DNC_DATA_W];
  endfunction

  // Erase/add update of the model, then queue r(i;k) head by head
  function automatic void model_operation();
    dnc_types_pkg::data_t gate;
    dnc_types_pkg::data_t m;
    dnc_types_pkg::data_t acc;
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) begin
        gate = q_mul(op_ww[j], op_erase[k]);
        m = model_mem[j][k];
        model_mem[j][k] = m - q_mul(m, gate) + q_mul(op_ww[j], op_add[k]);
      end
    end
    for (int i = 0; i < R; i++) begin
      for (int k = 0; k < W; k++) begin
        acc = '0;
        for (int j = 0; j < N; j++) begin
          acc = acc + q_mul(op_rw[i][j], model_mem[j][k]);
        end
        exp_q.push_back(acc);
      end
    end
  endfunction

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  task automatic halt_run();
    $display("Errors found");
    $fatal(1, "run stopped at the first error");
  endtask

  task automatic check_data(input dnc_types_pkg::data_t got,
                            input dnc_types_pkg::data_t exp, input int pos);
    if (got !== exp) begin
      $display("Mismatch at %0t: read element %0d is %h, expected %h", $time, pos, got, exp);
      halt_run();
    end
  endtask

  task automatic check_head(input dnc_types_pkg::head_idx_t got,
                            input dnc_types_pkg::head_idx_t exp);
    if (got !== exp) begin
      $display("Mismatch at %0t: r_out_i_enable marks head %0d, expected head %0d",
               $time, got, exp);
      halt_run();
    end
  endtask

  // Outputs are stable at the falling edge
  always @(negedge CLK) begin
    if (!RST) begin
      if (r_out_i_enable && !r_out_k_enable) begin
        $display("r_out_i_enable was high without r_out_k_enable at %0t", $time);
        halt_run();
      end else if (r_out_k_enable) begin
        if (exp_q.size() == 0) begin
          $display("A read element arrived at %0t with none expected", $time);
          halt_run();
        end else begin
          check_data(r_out, exp_q.pop_front(), elem_cnt);
          // Head starts counted from the DUT against the element position
          if (r_out_i_enable) begin
            check_head(dnc_types_pkg::head_idx_t'(head_cnt),
                       dnc_types_pkg::head_idx_t'(elem_cnt / W));
            head_cnt++;
          end else if (elem_cnt % W == 0) begin
            $display("Mismatch at %0t: r_out_i_enable is low on element %0d", $time,
                     elem_cnt);
            halt_run();
          end
          elem_cnt++;
        end
      end
      if (ready) begin
        if (elem_cnt != R * W) begin
          $display("ready pulsed after %0d read elements instead of %0d", elem_cnt, R * W);
          halt_run();
        end else begin
          elem_cnt = 0;
          head_cnt = 0;
          ready_cnt++;
        end
      end
    end
  end

  initial begin
    repeat (NUM_OPS * OP_CYCLES + 20) @(posedge CLK);
    $display("Timeout: the operations did not finish in the expected time");
    halt_run();
  end

  //////////////////////////////////////////////////////////////////////
  // Stimulus
  //////////////////////////////////////////////////////////////////////

  task automatic load_value(input dnc_ctrl_pkg::operand_e kind, input int head,
                            input int index, input dnc_types_pkg::data_t value);
    @(posedge CLK);
    #2;
    load_valid = 1'b1;
    load_kind  = kind;
    load_head  = dnc_types_pkg::head_idx_t'(head);
    load_index = dnc_types_pkg::elem_idx_t'(index);
    load_data  = value;
  endtask

  task automatic load_operands();
    for (int j = 0; j < N; j++) load_value(dnc_ctrl_pkg::OP_WRITE_WEIGHT, 0, j, op_ww[j]);
    for (int k = 0; k < W; k++) load_value(dnc_ctrl_pkg::OP_ERASE, 0, k, op_erase[k]);
    for (int k = 0; k < W; k++) load_value(dnc_ctrl_pkg::OP_WRITE_VEC, 0, k, op_add[k]);
    for (int i = 0; i < R; i++) begin
      for (int j = 0; j < N; j++) load_value(dnc_ctrl_pkg::OP_READ_WEIGHT, i, j, op_rw[i][j]);
    end
    @(posedge CLK);
    #2;
    load_valid = 1'b0;
  endtask

  task automatic pulse_start();
    @(posedge CLK);
    #2;
    start = 1'b1;
    @(posedge CLK);
    #2;
    start = 1'b0;
  endtask

  task automatic clear_operands();
    for (int j = 0; j < N; j++) op_ww[j] = '0;
    for (int k = 0; k < W; k++) begin
      op_erase[k] = '0;
      op_add[k]   = '0;
    end
    for (int i = 0; i < R; i++) begin
      for (int j = 0; j < N; j++) op_rw[i][j] = '0;
    end
  endtask

  task automatic randomize_operands();
    for (int j = 0; j < N; j++) op_ww[j] = dnc_types_pkg::data_t'($random(seed));
    for (int k = 0; k < W; k++) begin
      op_erase[k] = dnc_types_pkg::data_t'($random(seed));
      op_add[k]   = dnc_types_pkg::data_t'($random(seed));
    end
    for (int i = 0; i < R; i++) begin
      for (int j = 0; j < N; j++) op_rw[i][j] = dnc_types_pkg::data_t'($random(seed));
    end
  endtask

  // Load, start, then wait for the ready pulse of this operation
  task automatic run_operation(input bit do_load);
    int target;
    target = ready_cnt + 1;
    if (do_load) load_operands();
    model_operation();
    pulse_start();
    wait (ready_cnt == target);
  endtask

  initial begin
    int target;
    RST        = 1'b1;
    load_valid = 1'b0;
    load_kind  = dnc_ctrl_pkg::OP_WRITE_WEIGHT;
    load_head  = '0;
    load_index = '0;
    load_data  = '0;
    start      = 1'b0;
    clear_operands();
    for (int j = 0; j < N; j++) begin
      for (int k = 0; k < W; k++) model_mem[j][k] = '0;
    end
    repeat (4) @(posedge CLK);
    #2;
    RST = 1'b0;

    // Zero operands straight after reset
    run_operation(1'b0);

    // One-hot write on row 2, heads read rows 2 and 1
    clear_operands();
    op_ww[2] = 16'h0100;
    for (int k = 0; k < W; k++) op_add[k] = dnc_types_pkg::data_t'($random(seed));
    op_rw[0][2] = 16'h0100;
    op_rw[1][1] = 16'h0100;
    run_operation(1'b1);

    // Random operations on a persisting memory
    repeat (4) begin
      randomize_operands();
      run_operation(1'b1);
    end

    // Full erase, then a read of the cleared memory
    clear_operands();
    for (int j = 0; j < N; j++) op_ww[j] = 16'h0100;
    for (int k = 0; k < W; k++) op_erase[k] = 16'h0100;
    run_operation(1'b1);
    clear_operands();
    for (int j = 0; j < N; j++) op_rw[0][j] = dnc_types_pkg::data_t'($random(seed));
    for (int j = 0; j < N; j++) op_rw[1][j] = dnc_types_pkg::data_t'($random(seed));
    run_operation(1'b1);

    // Second start while busy must be ignored
    randomize_operands();
    target = ready_cnt + 1;
    load_operands();
    model_operation();
    pulse_start();
    repeat (2) @(posedge CLK);
    pulse_start();
    wait (ready_cnt == target);
    repeat (2 * N + R * W + 4) @(posedge CLK);

    if (ready_cnt != NUM_OPS || exp_q.size() != 0) begin
      $display("Saw %0d ready pulses for %0d operations, %0d elements missing",
               ready_cnt, NUM_OPS, exp_q.size());
      halt_run();
    end else begin
      $display("No errors");
      $finish;
    end
  end

endmodule

// File: dnc_addressing_top.sv
//////////////////////////////////////////////////////////////////////
// Top level of the memory update and read vector datapath. Operands
// are loaded one value per strobe, start runs one update plus read,
// and the read vectors come back as a stream ended by ready.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_addressing_top (
  input  logic                     CLK,
  input  logic                     RST,
  input  logic                     load_valid,
  input  dnc_ctrl_pkg::operand_e   load_kind,
  input  dnc_types_pkg::head_idx_t load_head,
  input  dnc_types_pkg::elem_idx_t load_index,
  input  dnc_types_pkg::data_t     load_data,
  input  logic                     start,
  output logic                     ready,
  output dnc_types_pkg::data_t     r_out,
  output logic                     r_out_i_enable,
  output logic                     r_out_k_enable
);

  logic                       busy;
  dnc_types_pkg::weight_vec_t write_weight;
  dnc_types_pkg::row_t        erase_vec;
  dnc_types_pkg::row_t        add_vec;
  dnc_types_pkg::weight_vec_t read_weight [`DNC_HEADS];
  dnc_types_pkg::row_t        head_result [`DNC_HEADS];
  logic [`DNC_HEADS-1:0]      head_valid;

  dnc_row_if rows ();

  dnc_operand_loader u_loader (
    .CLK          (CLK),
    .RST          (RST),
    .load_valid   (load_valid),
    .load_kind    (load_kind),
    .load_head    (load_head),
    .load_index   (load_index),
    .load_data    (load_data),
    .busy         (busy),
    .write_weight (write_weight),
    .erase_vec    (erase_vec),
    .add_vec      (add_vec),
    .read_weight  (read_weight)
  );

  dnc_memory_matrix u_matrix (
    .CLK          (CLK),
    .RST          (RST),
    .start        (start),
    .write_weight (write_weight),
    .erase_vec    (erase_vec),
    .add_vec      (add_vec),
    .busy         (busy),
    .rows         (rows)
  );

  // All heads read the same broadcast in parallel
  for (genvar gi = 0; gi < `DNC_HEADS; gi++) begin : g_head
    dnc_read_head u_head (
      .CLK          (CLK),
      .RST          (RST),
      .read_weight  (read_weight[gi]),
      .rows         (rows),
      .result       (head_result[gi]),
      .result_valid (head_valid[gi])
    );
  end

  dnc_read_collector u_collector (
    .CLK            (CLK),
    .RST            (RST),
    .results        (head_result),
    .results_valid  (head_valid),
    .r_out          (r_out),
    .r_out_i_enable (r_out_i_enable),
    .r_out_k_enable (r_out_k_enable),
    .ready          (ready)
  );

endmodule

// File: dnc_consts.svh
//////////////////////////////////////////////////////////////////////
// Array sizes and fixed-point format of the memory and read datapath.
// Include wherever a width or a count is needed; all sizes are fixed
// at compile time.
//////////////////////////////////////////////////////////////////////

`ifndef DNC_CONSTS_SVH
`define DNC_CONSTS_SVH

// Memory rows N
`define DNC_ROWS 4

// Elements per row W
`define DNC_WORD 4

// Read heads R
`define DNC_HEADS 2

// Q8.8 data format
`define DNC_DATA_W 16
`define DNC_FRAC 8

`endif

// File: dnc_ctrl_pkg.sv
//////////////////////////////////////////////////////////////////////
// Control encodings: operand selector of the load port and the state
// encodings of the matrix and collector FSMs.
//////////////////////////////////////////////////////////////////////

package dnc_ctrl_pkg;

  // Target of a load strobe
  typedef enum logic [1:0] {
    OP_WRITE_WEIGHT = 2'd0,
    OP_ERASE        = 2'd1,
    OP_WRITE_VEC    = 2'd2,
    OP_READ_WEIGHT  = 2'd3
  } operand_e;

  typedef enum logic [1:0] {
    MAT_IDLE      = 2'd0,
    MAT_UPDATE    = 2'd1,
    MAT_BROADCAST = 2'd2
  } matrix_state_e;

  typedef enum logic [1:0] {
    COL_IDLE  = 2'd0,
    COL_WAIT  = 2'd1,
    COL_DRAIN = 2'd2
  } collect_state_e;

endpackage

// File: dnc_memory_matrix.sv
//////////////////////////////////////////////////////////////////////
// Memory matrix M(j;k). On start it applies the erase/add update one
// row per cycle, then broadcasts every updated row on the row bus for
// the read heads. Contents persist from one operation to the next.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_memory_matrix (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       start,
  input  dnc_types_pkg::weight_vec_t write_weight,
  input  dnc_types_pkg::row_t        erase_vec,
  input  dnc_types_pkg::row_t        add_vec,
  output logic                       busy,
  dnc_row_if.source                  rows
);

  localparam dnc_types_pkg::row_idx_t LAST_ROW = dnc_types_pkg::row_idx_t'(`DNC_ROWS - 1);

  dnc_ctrl_pkg::matrix_state_e state;
  dnc_types_pkg::row_idx_t     row_cnt;
  dnc_types_pkg::row_t         mem [`DNC_ROWS];
  dnc_types_pkg::row_t         upd_row;

  //////////////////////////////////////////////////////////////////////
  // Row update datapath
  //////////////////////////////////////////////////////////////////////

  // M - M*(w*e) + w*v with every product truncated to Q8.8 and a wrapping sum
  always_comb begin
    dnc_types_pkg::data_t wj;
    dnc_types_pkg::data_t gate;
    dnc_types_pkg::data_t erased;
    dnc_types_pkg::data_t added;
    wj = write_weight[row_cnt];
    for (int k = 0; k < `DNC_WORD; k++) begin
      gate       = dnc_types_pkg::fx_mul(wj, erase_vec[k]);
      erased     = dnc_types_pkg::fx_mul(mem[row_cnt][k], gate);
      added      = dnc_types_pkg::fx_mul(wj, add_vec[k]);
      upd_row[k] = mem[row_cnt][k] - erased + added;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Sequencer
  //////////////////////////////////////////////////////////////////////

  // Memory starts out cleared
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state   <= dnc_ctrl_pkg::MAT_IDLE;
      row_cnt <= '0;
      for (int j = 0; j < `DNC_ROWS; j++) begin
        mem[j] <= '0;
      end
    end else begin
      case (state)
        dnc_ctrl_pkg::MAT_IDLE: begin
          // start is only looked at here
          if (start) begin
            state   <= dnc_ctrl_pkg::MAT_UPDATE;
            row_cnt <= '0;
          end
        end
        dnc_ctrl_pkg::MAT_UPDATE: begin
          mem[row_cnt] <= upd_row;
          if (row_cnt == LAST_ROW) begin
            state   <= dnc_ctrl_pkg::MAT_BROADCAST;
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        dnc_ctrl_pkg::MAT_BROADCAST: begin
          if (row_cnt == LAST_ROW) begin
            state   <= dnc_ctrl_pkg::MAT_IDLE;
            row_cnt <= '0;
          end else begin
            row_cnt <= row_cnt + 1'b1;
          end
        end
        default: begin
          state <= dnc_ctrl_pkg::MAT_IDLE;
        end
      endcase
    end
  end

  assign busy = (state != dnc_ctrl_pkg::MAT_IDLE);

  // Broadcast straight from the updated memory
  assign rows.row_valid = (state == dnc_ctrl_pkg::MAT_BROADCAST);
  assign rows.row_first = rows.row_valid && (row_cnt == '0);
  assign rows.row_last  = rows.row_valid && (row_cnt == LAST_ROW);
  assign rows.row_index = row_cnt;
  assign rows.row_data  = mem[row_cnt];

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // The last row comes N-1 rows after the first row of the same pass
  last_on_final_row_a : assert property (
    @(posedge CLK) disable iff (RST)
    rows.row_last |-> $past(rows.row_first, `DNC_ROWS - 1)
  ) else $error("row_last outside the final broadcast row");

  // A broadcast is one unbroken pass over all rows
  full_pass_a : assert property (
    @(posedge CLK) disable iff (RST)
    rows.row_first |-> rows.row_valid [*`DNC_ROWS] ##0 rows.row_last
  ) else $error("row broadcast pass broken before the last row");

endmodule

// File: dnc_operand_loader.sv
//////////////////////////////////////////////////////////////////////
// Operand registers for one memory operation. Each load strobe writes
// one value, selected by kind, head and index, into the write
// weighting, erase vector, write vector or a head's read weighting.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_operand_loader (
  input  logic                       CLK,
  input  logic                       RST,
  input  logic                       load_valid,
  input  dnc_ctrl_pkg::operand_e     load_kind,
  input  dnc_types_pkg::head_idx_t   load_head,
  input  dnc_types_pkg::elem_idx_t   load_index,
  input  dnc_types_pkg::data_t       load_data,
  input  logic                       busy,
  output dnc_types_pkg::weight_vec_t write_weight,
  output dnc_types_pkg::row_t        erase_vec,
  output dnc_types_pkg::row_t        add_vec,
  output dnc_types_pkg::weight_vec_t read_weight [`DNC_HEADS]
);

  // Weightings are indexed by row, the vectors by element
  dnc_types_pkg::row_idx_t row_sel;

  assign row_sel = dnc_types_pkg::row_idx_t'(load_index);

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      write_weight <= '0;
      erase_vec    <= '0;
      add_vec      <= '0;
      for (int h = 0; h < `DNC_HEADS; h++) begin
        read_weight[h] <= '0;
      end
    end else if (load_valid) begin
      case (load_kind)
        dnc_ctrl_pkg::OP_WRITE_WEIGHT: begin
          write_weight[row_sel] <= load_data;
        end
        dnc_ctrl_pkg::OP_ERASE: begin
          erase_vec[load_index] <= load_data;
        end
        dnc_ctrl_pkg::OP_WRITE_VEC: begin
          add_vec[load_index] <= load_data;
        end
        dnc_ctrl_pkg::OP_READ_WEIGHT: begin
          read_weight[load_head][row_sel] <= load_data;
        end
      endcase
    end
  end

  //////////////////////////////////////////////////////////////////////
  // Checks
  //////////////////////////////////////////////////////////////////////

  // Operands must stay stable while the matrix works through them
  load_idle_only_a : assert property (
    @(posedge CLK) disable iff (RST) load_valid |-> !busy
  ) else $error("operand load while the memory operation is busy");

endmodule

// File: dnc_read_collector.sv
//////////////////////////////////////////////////////////////////////
// Gathers the result rows of all read heads and streams them on r_out,
// head by head and element by element. r_out_i_enable marks the first
// element of each head; ready pulses after the last element.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_read_collector (
  input  logic                 CLK,
  input  logic                 RST,
  input  dnc_types_pkg::row_t  results [`DNC_HEADS],
  input  logic [`DNC_HEADS-1:0] results_valid,
  output dnc_types_pkg::data_t r_out,
  output logic                 r_out_i_enable,
  output logic                 r_out_k_enable,
  output logic                 ready
);

  localparam dnc_types_pkg::head_idx_t LAST_HEAD = dnc_types_pkg::head_idx_t'(`DNC_HEADS - 1);
  localparam dnc_types_pkg::elem_idx_t LAST_ELEM = dnc_types_pkg::elem_idx_t'(`DNC_WORD - 1);

  dnc_ctrl_pkg::collect_state_e state;
  logic [`DNC_HEADS-1:0]        got;
  dnc_types_pkg::head_idx_t     head_cnt;
  dnc_types_pkg::elem_idx_t     elem_cnt;
  dnc_types_pkg::row_t          held [`DNC_HEADS];

  // Latch each head's row as it arrives
  always_ff @(posedge CLK) begin
    for (int h = 0; h < `DNC_HEADS; h++) begin
      if (results_valid[h]) begin
        held[h] <= results[h];
      end
    end
  end

  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      state    <= dnc_ctrl_pkg::COL_IDLE;
      got      <= '0;
      head_cnt <= '0;
      elem_cnt <= '0;
      ready    <= 1'b0;
    end else begin
      ready <= 1'b0;
      case (state)
        dnc_ctrl_pkg::COL_IDLE: begin
          got <= results_valid;
          if (|results_valid) begin
            state <= dnc_ctrl_pkg::COL_WAIT;
          end
        end
        dnc_ctrl_pkg::COL_WAIT: begin
          got <= got | results_valid;
          if (&got) begin
            state    <= dnc_ctrl_pkg::COL_DRAIN;
            head_cnt <= '0;
            elem_cnt <= '0;
          end
        end
        dnc_ctrl_pkg::COL_DRAIN: begin
          if (elem_cnt == LAST_ELEM) begin
            elem_cnt <= '0;
            if (head_cnt == LAST_HEAD) begin
              state <= dnc_ctrl_pkg::COL_IDLE;
              got   <= '0;
              ready <= 1'b1;
            end else begin
              head_cnt <= head_cnt + 1'b1;
            end
          end else begin
            elem_cnt <= elem_cnt + 1'b1;
          end
        end
        default: begin
          state <= dnc_ctrl_pkg::COL_IDLE;
        end
      endcase
    end
  end

  // Output stream
  assign r_out          = held[head_cnt][elem_cnt];
  assign r_out_k_enable = (state == dnc_ctrl_pkg::COL_DRAIN);
  assign r_out_i_enable = r_out_k_enable && (elem_cnt == '0);

  // The held rows must not change under the stream
  no_result_in_drain_a : assert property (
    @(posedge CLK) disable iff (RST)
    (|results_valid) |-> (state != dnc_ctrl_pkg::COL_DRAIN)
  ) else $error("head result arrived while draining");

endmodule

// File: dnc_read_head.sv
//////////////////////////////////////////////////////////////////////
// One read head. Accumulates r(k) = sum over j of wr(j)*M(j;k) from
// the broadcast rows and pulses result_valid once the pass is done.
// Any number of heads can listen to the same broadcast.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

module dnc_read_head (
  input  logic                       CLK,
  input  logic                       RST,
  input  dnc_types_pkg::weight_vec_t read_weight,
  dnc_row_if.sink                    rows,
  output dnc_types_pkg::row_t        result,
  output logic                       result_valid
);

  dnc_types_pkg::data_t row_weight;
  dnc_types_pkg::row_t  term;

  // Weight for the row on the bus
  assign row_weight = read_weight[rows.row_index];

  always_comb begin
    for (int k = 0; k < `DNC_WORD; k++) begin
      term[k] = dnc_types_pkg::fx_mul(row_weight, rows.row_data[k]);
    end
  end

  // Accumulators restart on the first row of each pass
  always_ff @(posedge CLK) begin
    if (rows.row_valid) begin
      for (int k = 0; k < `DNC_WORD; k++) begin
        if (rows.row_first) begin
          result[k] <= term[k];
        end else begin
          result[k] <= result[k] + term[k];
        end
      end
    end
  end

  // Sum is complete the cycle after the last row
  always_ff @(posedge CLK or posedge RST) begin
    if (RST) begin
      result_valid <= 1'b0;
    end else begin
      result_valid <= rows.row_valid && rows.row_last;
    end
  end

endmodule

// File: dnc_row_if.sv
//////////////////////////////////////////////////////////////////////
// Row broadcast bus from the memory matrix to the read heads.
// One row per cycle while row_valid is high; first and last mark the
// ends of a full pass over the memory.
//////////////////////////////////////////////////////////////////////

interface dnc_row_if;

  logic                    row_valid;
  logic                    row_first;
  logic                    row_last;
  dnc_types_pkg::row_idx_t row_index;
  dnc_types_pkg::row_t     row_data;

  // Matrix side
  modport source (
    output row_valid,
    output row_first,
    output row_last,
    output row_index,
    output row_data
  );

  // Read head side
  modport sink (
    input row_valid,
    input row_first,
    input row_last,
    input row_index,
    input row_data
  );

endinterface

// File: dnc_types_pkg.sv
//////////////////////////////////////////////////////////////////////
// Data types of the memory datapath: Q8.8 words, index types and
// the row and weighting vectors built from them. Also holds the
// truncating fixed-point multiply shared by the matrix and the heads.
//////////////////////////////////////////////////////////////////////

`include "dnc_consts.svh"

package dnc_types_pkg;

  // One unsigned Q8.8 value
  typedef logic [`DNC_DATA_W-1:0] data_t;

  // Full-width product before the fraction shift
  typedef logic [2*`DNC_DATA_W-1:0] prod_t;

  typedef logic [$clog2(`DNC_ROWS)-1:0] row_idx_t;
  typedef logic [$clog2(`DNC_WORD)-1:0] elem_idx_t;
  typedef logic [$clog2(`DNC_HEADS)-1:0] head_idx_t;

  // One memory row, element k at index k
  typedef data_t [`DNC_WORD-1:0] row_t;

  // Weighting over the memory rows, row j at index j
  typedef data_t [`DNC_ROWS-1:0] weight_vec_t;

  // Q8.8 multiply, product shifted and cut back to 16 bits
  function automatic data_t fx_mul(data_t a, data_t b);
    prod_t p;
    p = prod_t'(a) * prod_t'(b);
    return data_t'(p >> `DNC_FRAC);
  endfunction

endpackage

// File: run_sim.sh
#!/bin/sh
# Compile the testbench and the design with Verilator, then run it.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert \
  -f dnc_addressing.f \
  --top-module dnc_addressing_tb \
  -o dnc_addressing_sim

out=$(./obj_dir/dnc_addressing_sim 2>&1) || true
echo "$out"

if echo "$out" | grep -qx "No errors"; then
  exit 0
fi
exit 1
